/* all.f */
+incdir+test
common/dsp_width_pkg.sv
common/dsp_ctrl_pkg.sv
operand/dsp_coeff_bank.sv
operand/dsp_operand_stage.sv
verilog/dsp_mult_stage.sv
verilog/dsp_accum_stage.sv
verilog/dsp_slice.sv
test/dsp_slice_tb.sv

/* run.sh */
#!/bin/sh
# Build the DSP slice testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dsp_slice_tb -f all.f -o dsp_slice_sim \
	&& ./obj_dir/dsp_slice_sim > sim.log 2>&1 \
	|| { echo "Verilator build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

/* test/dsp_slice_model.svh */
`ifndef DSP_SLICE_MODEL_SVH
`define DSP_SLICE_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'hfa5d;
localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

// All DUT inputs of one clock
typedef struct packed {
	mode_t      mode;
	logic       sub;
	logic       negate;
	logic       accumulate;
	logic       loadconst;
	logic       chain_add;
	logic       use_coeff;
	operand_t   x;
	operand_t   y;
	coeffs_t    coeff;
	bank_idx_t  idx;
	logic       we;
	logic       wsel;        // High writes bank A
	bank_addr_t waddr;
	coeff_t     wdata;
	result_t    chainin;     // Reaches the pins four cycles after the item
	result_t    constant;
} item_t;

logic [31:0] lfsr_state = LFSR_SEED;
coeff_t      model_bank_a [BANK_DEPTH];
coeff_t      model_bank_b [BANK_DEPTH];
result_t     model_result = '0;  // Previous output, as after reset

// Galois LFSR, one step per bit taken
function automatic logic [63:0] lfsr_bits(input int width);
	logic [63:0] bits;
	int          i;
	bits = '0;
	for (i = 0; i < width; i++) begin
		bits = {bits[62:0], lfsr_state[0]};
		lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
	end
	return bits;
endfunction

// Expected output of one item, its bank write lands before the read
function automatic result_t reference_result(input item_t it);
	half_t             p0, p1;
	logic [WIDE_W-1:0] pw, cw;
	coeff_t            c0, c1;
	bank_addr_t        ra, rb;
	result_t           v;
	result_t           r;
	int                i;
	if (it.we && it.wsel)
		model_bank_a[it.waddr] = it.wdata;
	else if (it.we)
		model_bank_b[it.waddr] = it.wdata;
	ra = it.idx[$bits(bank_addr_t)-1:0];
	rb = it.idx[$bits(bank_idx_t)-1:$bits(bank_addr_t)];
	c0 = it.use_coeff ? model_bank_a[ra] : it.coeff[COEFF_W-1:0];
	c1 = it.use_coeff ? model_bank_b[rb] : it.coeff[2*COEFF_W-1:COEFF_W];
	if (it.mode == MODE_DUAL) begin
		p0 = it.x[HALF_W-1:0] + it.y[HALF_W-1:0];
		p1 = it.x[OPERAND_W-1:HALF_W] + it.y[OPERAND_W-1:HALF_W];
		if (it.sub)
			v = result_t'(p0) * result_t'(c0) - result_t'(p1) * result_t'(c1);
		else
			v = result_t'(p0) * result_t'(c0) + result_t'(p1) * result_t'(c1);
	end else if (it.mode == MODE_WIDE) begin
		pw = it.x[WIDE_W-1:0] + it.y[WIDE_W-1:0];
		cw = it.use_coeff ? {c1[NARROW_W-1:0], c0} : it.coeff[WIDE_W-1:0];
		v = result_t'(pw) * result_t'(cw);
	end else begin
		v = '0;  // Codes 2 and 3, four lane products
		for (i = 0; i < 4; i++)
			v = v + result_t'(it.x[i*NARROW_W +: NARROW_W])
				* result_t'(it.y[i*NARROW_W +: NARROW_W]);
	end
	if (it.negate && it.mode < MODE_QUAD)
		v = -v;
	if (it.accumulate)
		r = v + model_result;
	else if (it.loadconst)
		r = it.constant;
	else if (it.chain_add)
		r = v + it.chainin;
	else
		r = v;
	model_result = r;
	return r;
endfunction

`endif

/* test/dsp_slice_tb.sv */
`timescale 1ns/10ps

module dsp_slice_tb;
	import dsp_width_pkg::*;
	import dsp_ctrl_pkg::*;

	`include "dsp_slice_model.svh"

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 3;
	localparam int PIPE_DEPTH   = 5;   // Input edge to resulta
	localparam int LATE_DEPTH   = 4;   // chainin and constant enter at the last stage
	localparam int DRAIN_LIMIT  = 20;

	logic       clk;
	logic       reset;
	mode_t      mode;
	logic       sub, negate, accumulate, loadconst, chain_add, use_coeff;
	operand_t   x_in, y_in;
	coeffs_t    coeff_in;
	bank_idx_t  coeff_idx;
	logic       coeff_we, coeff_sel;
	bank_addr_t coeff_addr;
	coeff_t     coeff_data;
	result_t    chainin, constant;
	result_t    resulta, chainout;

	result_t exp_val_q [$];
	string   exp_name_q [$];
	result_t chain_late_q [$];
	result_t const_late_q [$];
	string   test_name;
	result_t exp_value;
	string   exp_name;
	logic    checking;
	int      check_count;
	int      error_count;
	int      wait_count;
	item_t   it;

	dsp_slice dsp_slice_i (
		.clk        (clk),
		.reset      (reset),
		.mode       (mode),
		.sub        (sub),
		.negate     (negate),
		.accumulate (accumulate),
		.loadconst  (loadconst),
		.chain_add  (chain_add),
		.use_coeff  (use_coeff),
		.x_in       (x_in),
		.y_in       (y_in),
		.coeff_in   (coeff_in),
		.coeff_idx  (coeff_idx),
		.coeff_we   (coeff_we),
		.coeff_sel  (coeff_sel),
		.coeff_addr (coeff_addr),
		.coeff_data (coeff_data),
		.chainin    (chainin),
		.constant   (constant),
		.resulta    (resulta),
		.chainout   (chainout)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Random operands and coefficients, accumulator controls and write port off
	function automatic item_t make_item(input mode_t m);
		item_t r;
		r = '0;
		r.mode     = m;
		r.sub      = 1'(lfsr_bits(1));
		r.negate   = 1'(lfsr_bits(1));
		r.x        = operand_t'(lfsr_bits(OPERAND_W));
		r.y        = operand_t'(lfsr_bits(OPERAND_W));
		r.coeff    = coeffs_t'(lfsr_bits(2*COEFF_W));
		r.idx      = bank_idx_t'(lfsr_bits($bits(bank_idx_t)));
		r.chainin  = lfsr_bits(RESULT_W);
		r.constant = lfsr_bits(RESULT_W);
		return r;
	endfunction

	task automatic drive_item(input item_t t);
		@(negedge clk);
		mode       = t.mode;
		sub        = t.sub;
		negate     = t.negate;
		accumulate = t.accumulate;
		loadconst  = t.loadconst;
		chain_add  = t.chain_add;
		use_coeff  = t.use_coeff;
		x_in       = t.x;
		y_in       = t.y;
		coeff_in   = t.coeff;
		coeff_idx  = t.idx;
		coeff_we   = t.we;
		coeff_sel  = t.wsel;
		coeff_addr = t.waddr;
		coeff_data = t.wdata;
		// Late fields of the item four cycles back
		chain_late_q.push_back(t.chainin);
		const_late_q.push_back(t.constant);
		chainin  = chain_late_q.pop_front();
		constant = const_late_q.pop_front();
		exp_val_q.push_back(reference_result(t));
		exp_name_q.push_back(test_name);
	endtask

	// Every entry of both banks, with two idle cycles on each side
	task automatic write_banks();
		item_t w;
		int    n;
		test_name = "bank_write";
		for (n = 0; n < 2*BANK_DEPTH + 4; n++) begin
			w = make_item(MODE_DUAL);
			if (n >= 2 && n < 2*BANK_DEPTH + 2) begin
				w.we    = 1'b1;
				w.wsel  = 1'(n);
				w.waddr = bank_addr_t'((n - 2) / 2);
				w.wdata = coeff_t'(lfsr_bits(COEFF_W));
			end
			drive_item(w);
		end
		test_name = "bank_read";
	endtask

	// Output check, one expected value per falling edge
	always @(negedge clk) begin
		if (checking && exp_val_q.size() > 0) begin
			exp_value = exp_val_q.pop_front();
			exp_name  = exp_name_q.pop_front();
			check_count++;
			assert (resulta === exp_value) else begin
				error_count++;
				$display("Error %s: resulta expected %h, actual %h", exp_name, exp_value, resulta);
			end
			assert (chainout === exp_value) else begin
				error_count++;
				$display("Error %s: chainout expected %h, actual %h", exp_name, exp_value,
					chainout);
			end
		end
	end

	initial begin
		reset       = 1'b1;
		it          = '0;
		mode        = '0;
		{sub, negate, accumulate, loadconst, chain_add, use_coeff} = '0;
		x_in        = '0;
		y_in        = '0;
		coeff_in    = '0;
		coeff_idx   = '0;
		coeff_we    = 1'b0;
		coeff_sel   = 1'b0;
		coeff_addr  = '0;
		coeff_data  = '0;
		chainin     = '0;
		constant    = '0;
		checking    = 1'b0;
		check_count = 0;
		error_count = 0;
		test_name   = "reset";
		repeat (LATE_DEPTH) begin
			chain_late_q.push_back('0);
			const_late_q.push_back('0);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		// Pipeline is still empty for the first five checks
		repeat (PIPE_DEPTH) begin
			exp_val_q.push_back('0);
			exp_name_q.push_back(test_name);
		end
		checking = 1'b1;

		test_name = "dual_external";
		repeat (40) drive_item(make_item(MODE_DUAL));

		repeat (2) begin
			write_banks();
			repeat (24) begin
				it = make_item((lfsr_bits(1) != 0) ? MODE_WIDE : MODE_DUAL);
				it.use_coeff = 1'b1;
				drive_item(it);
			end
		end

		test_name = "quad";
		repeat (30) drive_item(make_item((lfsr_bits(1) != 0) ? MODE_QUAD : mode_t'(3)));

		test_name = "accum_chain";
		repeat (4) begin
			it = make_item(mode_t'(lfsr_bits(2)));
			it.use_coeff = 1'(lfsr_bits(1));
			it.loadconst = 1'b1;
			it.chain_add = 1'(lfsr_bits(1));  // Loadconst outranks the cascade
			drive_item(it);
			repeat (5) begin
				it = make_item(mode_t'(lfsr_bits(2)));
				it.use_coeff  = 1'(lfsr_bits(1));
				it.accumulate = 1'b1;
				it.loadconst  = 1'(lfsr_bits(1));
				it.chain_add  = 1'(lfsr_bits(1));
				drive_item(it);
			end
			repeat (4) begin
				it = make_item(mode_t'(lfsr_bits(2)));
				it.use_coeff = 1'(lfsr_bits(1));
				it.chain_add = 1'b1;
				drive_item(it);
			end
		end

		// Idle items push the last cascade words out
		test_name = "flush";
		it = '0;
		repeat (PIPE_DEPTH + 1) drive_item(it);

		wait_count = 0;
		while (exp_val_q.size() > 0 && wait_count < DRAIN_LIMIT) begin
			@(negedge clk);
			wait_count++;
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (exp_val_q.size() > 0) begin
			$display("Timeout: %0d expected results never reached the output", exp_val_q.size());
			$display("CHECKS FAILED");
		end else if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* verilog/dsp_slice.sv */
`timescale 1ns/10ps

module dsp_slice (
	input  logic                     clk,
	input  logic                     reset,
	input  dsp_ctrl_pkg::mode_t      mode,
	input  logic                     sub,
	input  logic                     negate,
	input  logic                     accumulate,
	input  logic                     loadconst,
	input  logic                     chain_add,
	input  logic                     use_coeff,
	input  dsp_width_pkg::operand_t  x_in,
	input  dsp_width_pkg::operand_t  y_in,
	input  dsp_width_pkg::coeffs_t   coeff_in,
	input  dsp_ctrl_pkg::bank_idx_t  coeff_idx,
	input  logic                     coeff_we,   // Bank write port
	input  logic                     coeff_sel,
	input  dsp_ctrl_pkg::bank_addr_t coeff_addr,
	input  dsp_width_pkg::coeff_t    coeff_data,
	input  dsp_width_pkg::result_t   chainin,
	input  dsp_width_pkg::result_t   constant,
	output dsp_width_pkg::result_t   resulta,
	output dsp_width_pkg::result_t   chainout
);
	import dsp_width_pkg::*;
	import dsp_ctrl_pkg::*;

	// Operand stage to multiplier
	mult_in_t op_a;
	mult_in_t op_b;
	mode_t    op_mode;
	logic     op_sub;
	logic     op_negate;
	logic     op_accumulate;
	logic     op_loadconst;
	logic     op_chain_add;

	// Multiplier to accumulator
	result_t comb_value;
	logic    comb_accumulate;
	logic    comb_loadconst;
	logic    comb_chain_add;

	result_t result;

	dsp_operand_stage operand_stage_i (
		.clk           (clk),
		.reset         (reset),
		.mode          (mode),
		.sub           (sub),
		.negate        (negate),
		.accumulate    (accumulate),
		.loadconst     (loadconst),
		.chain_add     (chain_add),
		.use_coeff     (use_coeff),
		.x_in          (x_in),
		.y_in          (y_in),
		.coeff_in      (coeff_in),
		.coeff_idx     (coeff_idx),
		.coeff_we      (coeff_we),
		.coeff_sel     (coeff_sel),
		.coeff_addr    (coeff_addr),
		.coeff_data    (coeff_data),
		.op_a          (op_a),
		.op_b          (op_b),
		.op_mode       (op_mode),
		.op_sub        (op_sub),
		.op_negate     (op_negate),
		.op_accumulate (op_accumulate),
		.op_loadconst  (op_loadconst),
		.op_chain_add  (op_chain_add)
	);

	dsp_mult_stage mult_stage_i (
		.clk             (clk),
		.reset           (reset),
		.op_a            (op_a),
		.op_b            (op_b),
		.op_mode         (op_mode),
		.op_sub          (op_sub),
		.op_negate       (op_negate),
		.op_accumulate   (op_accumulate),
		.op_loadconst    (op_loadconst),
		.op_chain_add    (op_chain_add),
		.comb_value      (comb_value),
		.comb_accumulate (comb_accumulate),
		.comb_loadconst  (comb_loadconst),
		.comb_chain_add  (comb_chain_add)
	);

	dsp_accum_stage accum_stage_i (
		.clk        (clk),
		.reset      (reset),
		.value      (comb_value),
		.accumulate (comb_accumulate),
		.loadconst  (comb_loadconst),
		.chain_add  (comb_chain_add),
		.chainin    (chainin),
		.constant   (constant),
		.result     (result)
	);

	// Both outputs come from the one output register
	assign resulta  = result;
	assign chainout = result;

endmodule

/* verilog/dsp_accum_stage.sv */
`timescale 1ns/10ps

module dsp_accum_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  dsp_width_pkg::result_t value,
	input  logic                   accumulate,
	input  logic                   loadconst,
	input  logic                   chain_add,
	input  dsp_width_pkg::result_t chainin,
	input  dsp_width_pkg::result_t constant,
	output dsp_width_pkg::result_t result
);
	import dsp_width_pkg::*;

	result_t addend;
	result_t sum;
	result_t result_next;

	// Second adder operand, own result or cascade
	always_comb begin
		if (accumulate)
			addend = result;  // Previous result
		else if (chain_add)
			addend = chainin;
		else
			addend = '0;
	end

	assign sum = value + addend;  // Wraps modulo 2^64

	// Priority: accumulate, then loadconst, then cascade add, then plain value
	always_comb begin
		if (loadconst && !accumulate)
			result_next = constant;
		else
			result_next = sum;
	end

	// Output register doubles as the accumulator
	always_ff @(posedge clk) begin
		if (reset)
			result <= '0;
		else
			result <= result_next;
	end

endmodule

/* verilog/dsp_mult_stage.sv */
`timescale 1ns/10ps

module dsp_mult_stage (
	input  logic                    clk,
	input  logic                    reset,
	input  dsp_width_pkg::mult_in_t op_a,
	input  dsp_width_pkg::mult_in_t op_b,
	input  dsp_ctrl_pkg::mode_t     op_mode,
	input  logic                    op_sub,
	input  logic                    op_negate,
	input  logic                    op_accumulate,
	input  logic                    op_loadconst,
	input  logic                    op_chain_add,
	output dsp_width_pkg::result_t  comb_value,
	output logic                    comb_accumulate,
	output logic                    comb_loadconst,
	output logic                    comb_chain_add
);
	import dsp_width_pkg::*;
	import dsp_ctrl_pkg::*;

	mult_in_t              dual0, dual1;
	logic [2*NARROW_W-1:0] quad0, quad1, quad2, quad3;
	product_t              wide_p, prod_next, prod_q;
	mode_t                 mode_q;
	logic                  sub_q, negate_q, acc_q, load_q, chain_q;
	logic                  quad_q;
	result_t               lane_lo, lane_hi, sum, value_next;

	// Dual lanes: pre-adder sum times coefficient
	assign dual0 = mult_in_t'(op_a[HALF_W-1:0]) * mult_in_t'(op_a[MULT_IN_W-1:HALF_W]);
	assign dual1 = mult_in_t'(op_b[HALF_W-1:0]) * mult_in_t'(op_b[MULT_IN_W-1:HALF_W]);

	// Quad lanes, x times y in each 18-bit pair
	assign quad0 = (2*NARROW_W)'(op_a[NARROW_W-1:0]) * (2*NARROW_W)'(op_a[2*NARROW_W-1:NARROW_W]);
	assign quad1 = (2*NARROW_W)'(op_a[3*NARROW_W-1:2*NARROW_W])
		* (2*NARROW_W)'(op_a[4*NARROW_W-1:3*NARROW_W]);
	assign quad2 = (2*NARROW_W)'(op_b[NARROW_W-1:0]) * (2*NARROW_W)'(op_b[2*NARROW_W-1:NARROW_W]);
	assign quad3 = (2*NARROW_W)'(op_b[3*NARROW_W-1:2*NARROW_W])
		* (2*NARROW_W)'(op_b[4*NARROW_W-1:3*NARROW_W]);

	assign wide_p = product_t'(op_a[WIDE_W-1:0]) * product_t'(op_b[WIDE_W-1:0]);

	always_comb begin
		if (op_mode >= MODE_QUAD)
			prod_next = {2'b00, quad3, quad2, quad1, quad0};
		else if (op_mode == MODE_WIDE)
			prod_next = wide_p;
		else
			prod_next = {dual1, dual0};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_q <= '0;
			mode_q <= '0;
			{sub_q, negate_q, acc_q, load_q, chain_q} <= '0;
		end else begin
			prod_q <= prod_next;
			mode_q <= op_mode;
			{sub_q, negate_q, acc_q, load_q, chain_q} <=
				{op_sub, op_negate, op_accumulate, op_loadconst, op_chain_add};
		end
	end

	assign quad_q  = (mode_q >= MODE_QUAD);
	assign lane_lo = result_t'(prod_q[MULT_IN_W-1:0]);
	assign lane_hi = result_t'(prod_q[PRODUCT_W-1:MULT_IN_W]);

	always_comb begin
		if (quad_q)
			sum = result_t'(quad_lane(prod_q, 0)) + result_t'(quad_lane(prod_q, 1))
				+ result_t'(quad_lane(prod_q, 2)) + result_t'(quad_lane(prod_q, 3));
		else if (mode_q == MODE_WIDE)
			sum = result_t'(prod_q[2*WIDE_W-1:0]);
		else
			sum = sub_q ? lane_lo - lane_hi : lane_lo + lane_hi;
	end

	// Quad mode ignores negate
	assign value_next = (negate_q && !quad_q) ? -sum : sum;

	always_ff @(posedge clk) begin
		if (reset) begin
			comb_value <= '0;
			comb_accumulate <= 1'b0;
			comb_loadconst <= 1'b0;
			comb_chain_add <= 1'b0;
		end else begin
			comb_value <= value_next;
			comb_accumulate <= acc_q;
			comb_loadconst <= load_q;
			comb_chain_add <= chain_q;
		end
	end

	// One 18-bit lane of the packed quad products
	function automatic logic [2*NARROW_W-1:0] quad_lane(input product_t p, input int idx);
		quad_lane = p[idx*2*NARROW_W +: 2*NARROW_W];
	endfunction

endmodule

/* operand/dsp_operand_stage.sv */
`timescale 1ns/10ps

module dsp_operand_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  dsp_ctrl_pkg::mode_t      mode,
	input  logic                     sub,
	input  logic                     negate,
	input  logic                     accumulate,
	input  logic                     loadconst,
	input  logic                     chain_add,
	input  logic                     use_coeff,
	input  dsp_width_pkg::operand_t  x_in,
	input  dsp_width_pkg::operand_t  y_in,
	input  dsp_width_pkg::coeffs_t   coeff_in,
	input  dsp_ctrl_pkg::bank_idx_t  coeff_idx,
	input  logic                     coeff_we,
	input  logic                     coeff_sel,
	input  dsp_ctrl_pkg::bank_addr_t coeff_addr,
	input  dsp_width_pkg::coeff_t    coeff_data,
	output dsp_width_pkg::mult_in_t  op_a,
	output dsp_width_pkg::mult_in_t  op_b,
	output dsp_ctrl_pkg::mode_t      op_mode,
	output logic                     op_sub,
	output logic                     op_negate,
	output logic                     op_accumulate,
	output logic                     op_loadconst,
	output logic                     op_chain_add
);
	import dsp_width_pkg::*;
	import dsp_ctrl_pkg::*;

	mode_t     mode_q;
	logic      sub_q, negate_q, accumulate_q, loadconst_q, chain_add_q, use_coeff_q;
	operand_t  x_q, y_q;
	coeffs_t   coeff_q;
	bank_idx_t idx_q;

	coeff_t                bank_a, bank_b;
	half_t                 pre0, pre1;
	logic [WIDE_W-1:0]     pre_wide, coef_wide;
	coeff_t                coef0, coef1;
	mult_in_t              a_next, b_next;

	// Input register, first pipeline stage
	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q <= '0;
			sub_q <= 1'b0;
			negate_q <= 1'b0;
			accumulate_q <= 1'b0;
			loadconst_q <= 1'b0;
			chain_add_q <= 1'b0;
			use_coeff_q <= 1'b0;
			x_q <= '0;
			y_q <= '0;
			coeff_q <= '0;
			idx_q <= '0;
		end else begin
			mode_q <= mode;
			sub_q <= sub;
			negate_q <= negate;
			accumulate_q <= accumulate;
			loadconst_q <= loadconst;
			chain_add_q <= chain_add;
			use_coeff_q <= use_coeff;
			x_q <= x_in;
			y_q <= y_in;
			coeff_q <= coeff_in;
			idx_q <= coeff_idx;
		end
	end

	dsp_coeff_bank coeff_bank_i (
		.clk    (clk),
		.we     (coeff_we),
		.sel    (coeff_sel),
		.waddr  (coeff_addr),
		.wdata  (coeff_data),
		.ridx   (idx_q),
		.coef_a (bank_a),
		.coef_b (bank_b)
	);

	// Pre-adders, each wraps at its own width
	assign pre0     = x_q[HALF_W-1:0] + y_q[HALF_W-1:0];
	assign pre1     = x_q[OPERAND_W-1:HALF_W] + y_q[OPERAND_W-1:HALF_W];
	assign pre_wide = x_q[WIDE_W-1:0] + y_q[WIDE_W-1:0];

	// External or bank coefficients
	assign coef0     = use_coeff_q ? bank_a : coeff_q[COEFF_W-1:0];
	assign coef1     = use_coeff_q ? bank_b : coeff_q[2*COEFF_W-1:COEFF_W];
	assign coef_wide = use_coeff_q ? {bank_b[NARROW_W-1:0], bank_a} : coeff_q[WIDE_W-1:0];

	always_comb begin
		case (mode_q)
			MODE_DUAL: begin
				a_next = {coef0, pre0};
				b_next = {coef1, pre1};
			end
			MODE_WIDE: begin
				a_next = {{(MULT_IN_W-WIDE_W){1'b0}}, pre_wide};
				b_next = {{(MULT_IN_W-WIDE_W){1'b0}}, coef_wide};
			end
			default: begin  // Quad, lanes 0 and 1 in a, lanes 2 and 3 in b, y above x
				a_next = {1'b0,
					y_q[2*NARROW_W-1:NARROW_W], x_q[2*NARROW_W-1:NARROW_W],
					y_q[NARROW_W-1:0], x_q[NARROW_W-1:0]};
				b_next = {1'b0,
					y_q[4*NARROW_W-1:3*NARROW_W], x_q[4*NARROW_W-1:3*NARROW_W],
					y_q[3*NARROW_W-1:2*NARROW_W], x_q[3*NARROW_W-1:2*NARROW_W]};
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_a <= '0;
			op_b <= '0;
			op_mode <= '0;
			op_sub <= 1'b0;
			op_negate <= 1'b0;
			op_accumulate <= 1'b0;
			op_loadconst <= 1'b0;
			op_chain_add <= 1'b0;
		end else begin
			op_a <= a_next;
			op_b <= b_next;
			op_mode <= mode_q;
			op_sub <= sub_q;
			op_negate <= negate_q;
			op_accumulate <= accumulate_q;
			op_loadconst <= loadconst_q;
			op_chain_add <= chain_add_q;
		end
	end

endmodule

/* operand/dsp_coeff_bank.sv */
`timescale 1ns/10ps

module dsp_coeff_bank (
	input  logic                     clk,
	input  logic                     we,
	input  logic                     sel,    // High selects bank A
	input  dsp_ctrl_pkg::bank_addr_t waddr,
	input  dsp_width_pkg::coeff_t    wdata,
	input  dsp_ctrl_pkg::bank_idx_t  ridx,
	output dsp_width_pkg::coeff_t    coef_a,
	output dsp_width_pkg::coeff_t    coef_b
);
	import dsp_width_pkg::*;
	import dsp_ctrl_pkg::*;

	coeff_t     mem_a [BANK_DEPTH];
	coeff_t     mem_b [BANK_DEPTH];
	bank_addr_t raddr_a;
	bank_addr_t raddr_b;

	// Write lands on the same edge as we
	always_ff @(posedge clk) begin
		if (we && sel)
			mem_a[waddr] <= wdata;
		if (we && !sel)
			mem_b[waddr] <= wdata;
	end

	assign raddr_a = ridx[$bits(bank_addr_t)-1:0];
	assign raddr_b = ridx[2*$bits(bank_addr_t)-1:$bits(bank_addr_t)];

	// Asynchronous read of both banks
	assign coef_a = mem_a[raddr_a];
	assign coef_b = mem_b[raddr_b];

endmodule

/* common/dsp_ctrl_pkg.sv */
package dsp_ctrl_pkg;

	// Multiplier mode select
	typedef logic [1:0] mode_t;

	localparam mode_t MODE_DUAL = 2'd0;  // Two 18x19 products
	localparam mode_t MODE_WIDE = 2'd1;  // One 27x27 product
	localparam mode_t MODE_QUAD = 2'd2;  // Four 9x9 products, code 3 aliases here

	// Coefficient bank geometry
	localparam int BANK_DEPTH = 8;

	typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;

	// Read index for both banks, bank A low and bank B high
	typedef logic [2*$bits(bank_addr_t)-1:0] bank_idx_t;

endpackage

/* common/dsp_width_pkg.sv */
package dsp_width_pkg;

	// Field widths of the data path
	localparam int HALF_W     = 19;  // Pre-adder half in dual mode
	localparam int OPERAND_W  = 2 * HALF_W;
	localparam int COEFF_W    = 18;
	localparam int MULT_IN_W  = COEFF_W + HALF_W;  // Coefficient above pre-adder sum
	localparam int PRODUCT_W  = 2 * MULT_IN_W;
	localparam int RESULT_W   = 64;

	// Quad mode lane and single mode operand
	localparam int NARROW_W   = 9;
	localparam int WIDE_W     = 27;

	// One half of x or y in dual mode
	typedef logic [HALF_W-1:0] half_t;

	// Full x or y input
	typedef logic [OPERAND_W-1:0] operand_t;

	// Coefficient word, as stored in the banks
	typedef logic [COEFF_W-1:0] coeff_t;

	// External coefficient pair
	typedef logic [2*COEFF_W-1:0] coeffs_t;

	// Multiplier operand lane
	typedef logic [MULT_IN_W-1:0] mult_in_t;

	// Raw multiplier output, two lanes side by side
	typedef logic [PRODUCT_W-1:0] product_t;

	// Combined value, accumulator, constant and cascade
	typedef logic [RESULT_W-1:0] result_t;

endpackage
